// ==== flist.f ====
logic/fmc_i2c_pkg.sv
logic/i2c_line_sampler.sv
logic/i2c_scl_gen.sv
logic/i2c_bit_engine.sv
logic/fmc_init_sequencer.sv
logic/fmc_i2c_init_top.sv
verif/i2c_slave_model.sv
verif/tb_fmc_i2c_init.sv

// ==== logic/fmc_i2c_init_top.sv ====
`timescale 1ns/1ps

module fmc_i2c_init_top (
    input  logic CLK,
    input  logic delay_rst_reg,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_drive_low_o,
    output logic sda_drive_low_o,
    output logic done_o
);

    fmc_i2c_pkg::line_t       line;
    fmc_i2c_pkg::scl_phase_t  phase;
    fmc_i2c_pkg::byte_cmd_t   cmd;
    fmc_i2c_pkg::byte_rsp_t   rsp;
    logic                     cmd_valid;
    logic                     cmd_take;
    logic                     run;

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////

    i2c_line_sampler u_sampler (
        .CLK           (CLK),
        .delay_rst_reg (delay_rst_reg),
        .scl_i         (scl_i),
        .sda_i         (sda_i),
        .line_o        (line)
    );

    //////////////////////////////////////////////////////////////////////
    // Byte sequencing and bit timing
    //////////////////////////////////////////////////////////////////////

    fmc_init_sequencer u_sequencer (
        .CLK           (CLK),
        .delay_rst_reg (delay_rst_reg),
        .cmd_o         (cmd),
        .cmd_valid_o   (cmd_valid),
        .cmd_take_i    (cmd_take),
        .rsp_i         (rsp),
        .done_o        (done_o)
    );

    // Bit engine owns SDA and tells the clock when to run
    i2c_bit_engine u_bit_engine (
        .CLK             (CLK),
        .delay_rst_reg   (delay_rst_reg),
        .cmd_i           (cmd),
        .cmd_valid_i     (cmd_valid),
        .cmd_take_o      (cmd_take),
        .rsp_o           (rsp),
        .line_i          (line),
        .phase_i         (phase),
        .run_o           (run),
        .sda_drive_low_o (sda_drive_low_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    i2c_scl_gen u_scl_gen (
        .CLK             (CLK),
        .delay_rst_reg   (delay_rst_reg),
        .run_i           (run),
        .line_i          (line),
        .scl_drive_low_o (scl_drive_low_o),
        .phase_o         (phase)
    );

endmodule

// ==== logic/fmc_i2c_pkg.sv ====
package fmc_i2c_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus timing
    //////////////////////////////////////////////////////////////////////

    // CLK cycles in one SCL half period
    localparam logic [7:0] SCL_HALF_CYCLES = 8'd10;

    // Depth of the line synchronizer chain
    localparam int SYNC_STAGES = 2;

    //////////////////////////////////////////////////////////////////////
    // Init byte table
    //////////////////////////////////////////////////////////////////////

    localparam int INIT_BYTES = 5;

    // Entry 0 goes out first
    // Group A is the bus switch address with write bit, then the channel select
    // Group B is the CPLD address with write bit, the control register, then LED4 on
    localparam logic [INIT_BYTES-1:0][7:0] INIT_TABLE = {
        8'h01,
        8'h02,
        8'h7C,
        8'h80,
        8'hE2
    };

    typedef logic [2:0] tbl_idx_t;

    // First and last table entries of each write transaction
    localparam tbl_idx_t GROUP_A_FIRST = 3'd0;
    localparam tbl_idx_t GROUP_A_LAST  = 3'd1;
    localparam tbl_idx_t GROUP_B_FIRST = 3'd2;
    localparam tbl_idx_t GROUP_B_LAST  = 3'd4;

    //////////////////////////////////////////////////////////////////////
    // Shared bundles
    //////////////////////////////////////////////////////////////////////

    // Synchronized line levels
    typedef struct packed {
        logic scl;
        logic sda;
    } line_t;

    // One-cycle pulses in the middle of each SCL half
    typedef struct packed {
        logic mid_low;
        logic mid_high;
    } scl_phase_t;

    // A stop command carries no data, a restart command carries the byte to resend
    typedef struct packed {
        logic [7:0] data;
        logic       with_start;
        logic       with_stop;
        logic       restart;
    } byte_cmd_t;

    typedef struct packed {
        logic done;
        logic acked;
    } byte_rsp_t;

endpackage

// ==== logic/fmc_init_sequencer.sv ====
`timescale 1ns/1ps

module fmc_init_sequencer (
    input  logic                    CLK,
    input  logic                    delay_rst_reg,
    output fmc_i2c_pkg::byte_cmd_t  cmd_o,
    output logic                    cmd_valid_o,
    input  logic                    cmd_take_i,
    input  fmc_i2c_pkg::byte_rsp_t  rsp_i,
    output logic                    done_o
);

    fmc_i2c_pkg::tbl_idx_t   idx_q;
    // Flags describing the next command to build
    logic                    start_q;
    logic                    restart_q;
    logic                    stop_pend_q;
    // One-cycle request to load the command register
    logic                    issue_q;
    logic                    cmd_valid_q;
    logic                    done_q;
    fmc_i2c_pkg::byte_cmd_t  cmd_q;
    logic                    at_group_end;
    logic                    in_group_a;

    assign at_group_end = (idx_q == fmc_i2c_pkg::GROUP_A_LAST) ||
                          (idx_q == fmc_i2c_pkg::GROUP_B_LAST);
    assign in_group_a   = (idx_q <= fmc_i2c_pkg::GROUP_A_LAST);

    //////////////////////////////////////////////////////////////////////
    // Table walk
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            idx_q       <= fmc_i2c_pkg::GROUP_A_FIRST;
            start_q     <= 1'b1;
            restart_q   <= 1'b0;
            stop_pend_q <= 1'b0;
            issue_q     <= 1'b1;
            cmd_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            if (issue_q) begin
                cmd_valid_q <= 1'b1;
            end
            // Start and restart markers apply to one command only
            if (cmd_take_i) begin
                cmd_valid_q <= 1'b0;
                start_q     <= 1'b0;
                restart_q   <= 1'b0;
            end
            if (rsp_i.done) begin
                if (stop_pend_q) begin
                    stop_pend_q <= 1'b0;
                    if (idx_q == fmc_i2c_pkg::GROUP_B_LAST) begin
                        // Whole sequence is on the board, nothing more is issued
                        done_q <= 1'b1;
                    end else begin
                        idx_q   <= fmc_i2c_pkg::GROUP_B_FIRST;
                        start_q <= 1'b1;
                        issue_q <= 1'b1;
                    end
                end else if (!rsp_i.acked) begin
                    // Refused byte sends the current group again from its first byte
                    idx_q     <= in_group_a ? fmc_i2c_pkg::GROUP_A_FIRST
                                            : fmc_i2c_pkg::GROUP_B_FIRST;
                    restart_q <= 1'b1;
                    issue_q   <= 1'b1;
                end else if (at_group_end) begin
                    stop_pend_q <= 1'b1;
                    issue_q     <= 1'b1;
                end else begin
                    idx_q   <= idx_q + 3'd1;
                    issue_q <= 1'b1;
                end
            end
        end
    end

    // Command payload is built from the flags one cycle after the decision
    always_ff @(posedge CLK) begin
        if (issue_q) begin
            cmd_q.data       <= fmc_i2c_pkg::INIT_TABLE[idx_q];
            cmd_q.with_start <= start_q;
            cmd_q.with_stop  <= stop_pend_q;
            cmd_q.restart    <= restart_q;
        end
    end

    assign cmd_o       = cmd_q;
    assign cmd_valid_o = cmd_valid_q;
    assign done_o      = done_q;

endmodule

// ==== logic/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                     CLK,
    input  logic                     delay_rst_reg,
    input  fmc_i2c_pkg::byte_cmd_t   cmd_i,
    input  logic                     cmd_valid_i,
    output logic                     cmd_take_o,
    output fmc_i2c_pkg::byte_rsp_t   rsp_o,
    input  fmc_i2c_pkg::line_t       line_i,
    input  fmc_i2c_pkg::scl_phase_t  phase_i,
    output logic                     run_o,
    output logic                     sda_drive_low_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_RESTART,
        ST_DATA,
        ST_ACK,
        ST_STOP
    } state_t;

    state_t                  state_q;
    logic [7:0]              sh_q;
    // Counts data bits already placed on SDA, 0 to 8
    logic [3:0]              bit_cnt_q;
    logic                    run_q;
    logic                    sda_low_q;
    fmc_i2c_pkg::byte_rsp_t  rsp_q;
    logic                    take_idle;
    logic                    take_ack;

    // A new transaction only begins from idle and only with a START
    assign take_idle  = (state_q == ST_IDLE) && cmd_valid_i && cmd_i.with_start;
    // Follow-on commands are taken where the ACK slot ends
    assign take_ack   = (state_q == ST_ACK) && phase_i.mid_low && cmd_valid_i;
    assign cmd_take_o = take_idle || take_ack;

    //////////////////////////////////////////////////////////////////////
    // Bus condition FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= 4'd0;
            run_q     <= 1'b0;
            sda_low_q <= 1'b0;
            rsp_q     <= '0;
        end else begin
            rsp_q.done <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (take_idle) begin
                        run_q   <= 1'b1;
                        state_q <= ST_START;
                    end
                end
                // SDA falls while SCL is high
                ST_START: begin
                    if (phase_i.mid_high) begin
                        sda_low_q <= 1'b1;
                        bit_cnt_q <= 4'd0;
                        state_q   <= ST_DATA;
                    end
                end
                // SDA was released when the command was taken
                ST_RESTART: begin
                    if (phase_i.mid_high) begin
                        sda_low_q <= 1'b1;
                        bit_cnt_q <= 4'd0;
                        state_q   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (phase_i.mid_low) begin
                        if (bit_cnt_q == 4'd8) begin
                            // Hand SDA to the slave for its ACK
                            sda_low_q <= 1'b0;
                            state_q   <= ST_ACK;
                        end else begin
                            sda_low_q <= ~sh_q[7];
                            bit_cnt_q <= bit_cnt_q + 4'd1;
                        end
                    end
                end
                ST_ACK: begin
                    if (phase_i.mid_high) begin
                        // Slave pulls SDA low to acknowledge
                        rsp_q.done  <= 1'b1;
                        rsp_q.acked <= ~line_i.sda;
                    end else if (take_ack) begin
                        if (cmd_i.with_stop) begin
                            sda_low_q <= 1'b1;
                            state_q   <= ST_STOP;
                        end else if (cmd_i.restart) begin
                            sda_low_q <= 1'b0;
                            state_q   <= ST_RESTART;
                        end else begin
                            // MSB goes out right away at this mid-low point
                            sda_low_q <= ~cmd_i.data[7];
                            bit_cnt_q <= 4'd1;
                            state_q   <= ST_DATA;
                        end
                    end
                end
                // SDA rises while SCL is high, then the clock stops
                ST_STOP: begin
                    if (phase_i.mid_high) begin
                        sda_low_q   <= 1'b0;
                        run_q       <= 1'b0;
                        rsp_q.done  <= 1'b1;
                        rsp_q.acked <= 1'b1;
                        state_q     <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Byte shift register loads on take and shifts out MSB first
    always_ff @(posedge CLK) begin
        if (take_idle) begin
            sh_q <= cmd_i.data;
        end else if (take_ack) begin
            // A plain byte has already put its MSB on the line
            sh_q <= (cmd_i.restart) ? cmd_i.data : {cmd_i.data[6:0], 1'b0};
        end else if (state_q == ST_DATA && phase_i.mid_low) begin
            sh_q <= {sh_q[6:0], 1'b0};
        end
    end

    assign run_o           = run_q;
    assign sda_drive_low_o = sda_low_q;
    assign rsp_o           = rsp_q;

endmodule

// ==== logic/i2c_line_sampler.sv ====
`timescale 1ns/1ps

module i2c_line_sampler (
    input  logic                CLK,
    input  logic                delay_rst_reg,
    input  logic                scl_i,
    input  logic                sda_i,
    output fmc_i2c_pkg::line_t  line_o
);

    // Raw pin levels gathered into one bundle
    fmc_i2c_pkg::line_t pin;

    // Stage 0 takes the pins, the last stage feeds the logic
    fmc_i2c_pkg::line_t [fmc_i2c_pkg::SYNC_STAGES-1:0] sync_q;

    assign pin.scl = scl_i;
    assign pin.sda = sda_i;

    // Both lines idle high on an open-drain bus, so the chain resets to ones
    always_ff @(posedge CLK) begin
        if (delay_rst_reg) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[fmc_i2c_pkg::SYNC_STAGES-2:0], pin};
        end
    end

    // Output trails the pins by exactly SYNC_STAGES cycles
    assign line_o = sync_q[fmc_i2c_pkg::SYNC_STAGES-1];

endmodule

// ==== logic/i2c_scl_gen.sv ====
`timescale 1ns/1ps

module i2c_scl_gen (
    input  logic                     CLK,
    input  logic                     delay_rst_reg,
    input  logic                     run_i,
    input  fmc_i2c_pkg::line_t       line_i,
    output logic                     scl_drive_low_o,
    output fmc_i2c_pkg::scl_phase_t  phase_o
);

    // High while this side pulls SCL down
    logic       low_q;
    logic [7:0] cnt_q;
    logic       half_end;
    logic       at_mid;

    assign half_end = (cnt_q == fmc_i2c_pkg::SCL_HALF_CYCLES - 8'd1);
    assign at_mid   = (cnt_q == (fmc_i2c_pkg::SCL_HALF_CYCLES >> 1));

    //////////////////////////////////////////////////////////////////////
    // Half period counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        // Stopped generator leaves SCL released and re-enters in a high half
        if (delay_rst_reg || !run_i) begin
            low_q <= 1'b0;
            cnt_q <= 8'd0;
        end else if (low_q) begin
            // The low half is timed locally and lasts exactly one half period
            if (half_end) begin
                low_q <= 1'b0;
                cnt_q <= 8'd0;
            end else begin
                cnt_q <= cnt_q + 8'd1;
            end
        end else if (cnt_q == 8'd0 && !line_i.scl) begin
            // SCL released but still read low
            // Either the synchronizer lags or a slave is stretching the clock
            cnt_q <= 8'd0;
        end else if (half_end) begin
            low_q <= 1'b1;
            cnt_q <= 8'd0;
        end else begin
            cnt_q <= cnt_q + 8'd1;
        end
    end

    assign scl_drive_low_o = low_q;

    // A nonzero count in the released half means SCL has been seen high
    assign phase_o.mid_low  = low_q && at_mid;
    assign phase_o.mid_high = !low_q && at_mid;

endmodule

// ==== verif/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model (
    input  logic        CLK,
    input  logic        delay_rst_reg,
    input  logic        scl_i,
    input  logic        sda_i,
    input  logic [7:0]  nack_data_i,
    input  int          nack_attempt_i,
    input  int          stretch_i,
    output logic        scl_low_o,
    output logic        sda_low_o,
    output logic        ev_valid_o,
    output logic [10:0] ev_o
);

    // Previous bus levels for edge and condition detection
    logic       scl_q;
    logic       sda_q;
    // High between a START and the matching STOP
    logic       busy_q;
    // 0 to 7 while data bits arrive, 8 after the byte, 9 in the ACK slot
    logic [3:0] bit_cnt_q;
    logic [7:0] sh_q;
    logic       ack_q;
    // How many times the refusable byte value has arrived so far
    int         seen_q;
    int         hold_q;
    logic [7:0] rx_byte;

    //////////////////////////////////////////////////////////////////////
    // Bus decoder, works on the falling CLK edge where both lines are stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (delay_rst_reg) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            busy_q     <= 1'b0;
            bit_cnt_q  <= 4'd0;
            sh_q       <= 8'h00;
            ack_q      <= 1'b1;
            seen_q     <= 0;
            hold_q     <= 0;
            scl_low_o  <= 1'b0;
            sda_low_o  <= 1'b0;
            ev_valid_o <= 1'b0;
            ev_o       <= '0;
        end else begin
            scl_q      <= scl_i;
            sda_q      <= sda_i;
            ev_valid_o <= 1'b0;
            // Let go of a stretched clock once the hold time runs out
            if (hold_q != 0) begin
                hold_q <= hold_q - 1;
                if (hold_q == 1) begin
                    scl_low_o <= 1'b0;
                end
            end
            if (scl_i && scl_q && sda_q && !sda_i) begin
                // SDA falls with SCL high, a START or a repeated START when busy
                ev_o       <= {!busy_q, busy_q, 1'b0, 8'h00};
                ev_valid_o <= 1'b1;
                busy_q     <= 1'b1;
                bit_cnt_q  <= 4'd0;
            end else if (scl_i && scl_q && !sda_q && sda_i) begin
                // SDA rises with SCL high, a STOP
                ev_o       <= {3'b001, 8'h00};
                ev_valid_o <= 1'b1;
                busy_q     <= 1'b0;
                bit_cnt_q  <= 4'd0;
            end else if (busy_q && scl_i && !scl_q && bit_cnt_q < 4'd8) begin
                // Data is sampled on the rising SCL edge, MSB first
                rx_byte = {sh_q[6:0], sda_i};
                sh_q      <= rx_byte;
                bit_cnt_q <= bit_cnt_q + 4'd1;
                if (bit_cnt_q == 4'd7) begin
                    ev_o       <= {3'b000, rx_byte};
                    ev_valid_o <= 1'b1;
                    // Refuse only the planned arrival of the planned byte
                    if (rx_byte == nack_data_i) begin
                        seen_q <= seen_q + 1;
                        ack_q  <= (seen_q + 1 != nack_attempt_i);
                    end else begin
                        ack_q <= 1'b1;
                    end
                end
            end else if (busy_q && !scl_i && scl_q) begin
                if (bit_cnt_q == 4'd8) begin
                    // Byte done, present the ACK for the ninth clock
                    sda_low_o <= ack_q;
                    bit_cnt_q <= 4'd9;
                end else if (bit_cnt_q == 4'd9) begin
                    // ACK slot is over, free SDA and maybe hold SCL down a while
                    sda_low_o <= 1'b0;
                    bit_cnt_q <= 4'd0;
                    if (stretch_i > 0) begin
                        scl_low_o <= 1'b1;
                        hold_q    <= stretch_i;
                    end
                end
            end
        end
    end

endmodule

// ==== verif/tb_fmc_i2c_init.sv ====
`timescale 1ns/1ps

module tb_fmc_i2c_init;

    localparam int HALF = int'(fmc_i2c_pkg::SCL_HALF_CYCLES);
    // Extra low time per stretched ACK is STRETCH_MIN plus up to STRETCH_SPAN - 1
    localparam int STRETCH_MIN  = HALF + 2;
    localparam int STRETCH_SPAN = 16;
    // Worst case per test is five bytes, five resent bytes and two stops
    localparam int WORST_BYTES  = 5 + 5 + 2;
    localparam int TEST_COUNT   = 5;
    localparam int BYTE_CYCLES  = 9 * 2 * HALF + STRETCH_MIN + STRETCH_SPAN;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * WORST_BYTES * BYTE_CYCLES * 6 / 5;

    // One decoded bus event from the slave model
    typedef struct packed {
        logic       start;
        logic       restart;
        logic       stop;
        logic [7:0] data;
    } log_entry_t;

    logic        CLK;
    logic        delay_rst_reg;
    logic        scl_i;
    logic        sda_i;
    logic        scl_drive_low_o;
    logic        sda_drive_low_o;
    logic        done_o;
    logic        slave_scl_low;
    logic        slave_sda_low;
    logic        bus_scl;
    logic        bus_sda;
    logic        ev_valid;
    logic [10:0] ev_word;
    logic [7:0]  nack_data;
    int          nack_attempt;
    int          stretch_len;
    integer      seed;
    int          error_count;
    int          cycle_cnt;
    // SCL phase lengths seen since the last reset
    int          run_len;
    logic        last_scl;
    int          min_high;
    int          max_low;
    log_entry_t  log_q[$];
    log_entry_t  exp_q[$];

    fmc_i2c_init_top u_dut (
        .CLK             (CLK),
        .delay_rst_reg   (delay_rst_reg),
        .scl_i           (scl_i),
        .sda_i           (sda_i),
        .scl_drive_low_o (scl_drive_low_o),
        .sda_drive_low_o (sda_drive_low_o),
        .done_o          (done_o)
    );

    i2c_slave_model u_slave (
        .CLK            (CLK),
        .delay_rst_reg  (delay_rst_reg),
        .scl_i          (bus_scl),
        .sda_i          (bus_sda),
        .nack_data_i    (nack_data),
        .nack_attempt_i (nack_attempt),
        .stretch_i      (stretch_len),
        .scl_low_o      (slave_scl_low),
        .sda_low_o      (slave_sda_low),
        .ev_valid_o     (ev_valid),
        .ev_o           (ev_word)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock, open-drain bus and monitors
    //////////////////////////////////////////////////////////////////////

    always #10 CLK = ~CLK;

    // Wired-AND of both sides with a pull-up
    assign bus_scl = ~(scl_drive_low_o | slave_scl_low);
    assign bus_sda = ~(sda_drive_low_o | slave_sda_low);

    // Line levels reach the DUT on the falling edge
    always @(negedge CLK) begin
        scl_i <= bus_scl;
        sda_i <= bus_sda;
    end

    always @(posedge CLK) begin
        if (ev_valid) begin
            log_q.push_back(log_entry_t'(ev_word));
        end
    end

    // Length of each SCL high and low phase as the DUT sees it
    always @(posedge CLK) begin
        if (delay_rst_reg) begin
            run_len  = 0;
            last_scl = 1'b1;
            min_high = 1000000;
            max_low  = 0;
        end else if (scl_i === last_scl) begin
            run_len = run_len + 1;
        end else begin
            if (last_scl && run_len < min_high) begin
                min_high = run_len;
            end else if (!last_scl && run_len > max_low) begin
                max_low = run_len;
            end
            last_scl = scl_i;
            run_len  = 1;
        end
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the init sequence did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and helpers
    //////////////////////////////////////////////////////////////////////

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp,
                                input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s, got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic log_entry_t make_entry(input logic s, input logic r,
                                              input logic p, input logic [7:0] d);
        log_entry_t e;
        e.start   = s;
        e.restart = r;
        e.stop    = p;
        e.data    = d;
        return e;
    endfunction

    // Expected traffic, group by group, with a repeated START and a resend on a refusal
    task automatic build_expected(input int nack_idx, input int nack_attempts);
        int first;
        int last;
        int i;
        int seen;
        exp_q.delete();
        seen = 0;
        for (int g = 0; g < 2; g++) begin
            first = (g == 0) ? fmc_i2c_pkg::GROUP_A_FIRST : fmc_i2c_pkg::GROUP_B_FIRST;
            last  = (g == 0) ? fmc_i2c_pkg::GROUP_A_LAST : fmc_i2c_pkg::GROUP_B_LAST;
            exp_q.push_back(make_entry(1'b1, 1'b0, 1'b0, 8'h00));
            i = first;
            while (i <= last) begin
                exp_q.push_back(make_entry(1'b0, 1'b0, 1'b0, fmc_i2c_pkg::INIT_TABLE[i]));
                if (i == nack_idx) begin
                    seen++;
                end
                if (i == nack_idx && seen == nack_attempts) begin
                    exp_q.push_back(make_entry(1'b0, 1'b1, 1'b0, 8'h00));
                    i = first;
                end else begin
                    i++;
                end
            end
            exp_q.push_back(make_entry(1'b0, 1'b0, 1'b1, 8'h00));
        end
    endtask

    task automatic check_log(input string name);
        int n;
        log_entry_t got;
        log_entry_t exp;
        compare_flag(log_q.size() == exp_q.size(), 1'b1,
                     $sformatf("%s log has %0d entries, expected %0d",
                               name, log_q.size(), exp_q.size()));
        n = (log_q.size() < exp_q.size()) ? log_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            got = log_q[i];
            exp = exp_q[i];
            compare_flag(got.start, exp.start, $sformatf("%s entry %0d START", name, i));
            compare_flag(got.restart, exp.restart,
                         $sformatf("%s entry %0d repeated START", name, i));
            compare_flag(got.stop, exp.stop, $sformatf("%s entry %0d STOP", name, i));
            compare_byte(got.data, exp.data, $sformatf("%s entry %0d data", name, i));
        end
    endtask

    task automatic check_idle(input string when);
        compare_flag(scl_drive_low_o, 1'b0, {"scl_drive_low_o ", when});
        compare_flag(sda_drive_low_o, 1'b0, {"sda_drive_low_o ", when});
        compare_flag(done_o, 1'b0, {"done_o ", when});
    endtask

    // Reset is held for 3 CLK cycles
    task automatic reset_dut(input logic watch_idle);
        @(negedge CLK);
        delay_rst_reg <= 1'b1;
        repeat (3) begin
            @(negedge CLK);
            log_q.delete();
            if (watch_idle) begin
                check_idle("during reset");
            end
        end
        delay_rst_reg <= 1'b0;
    endtask

    // Runs the whole init with one slave setup and checks the bus log
    task automatic run_init(input string name, input int nack_idx,
                            input int nack_attempts, input logic stretch_on);
        int logged;
        nack_data    <= (nack_idx >= 0) ? fmc_i2c_pkg::INIT_TABLE[nack_idx] : 8'h00;
        nack_attempt <= nack_attempts;
        stretch_len  <= 0;
        reset_dut(1'b0);
        build_expected(nack_idx, nack_attempts);
        logged = 0;
        while (done_o !== 1'b1) begin
            @(negedge CLK);
            // A new stretch length is drawn as bytes arrive
            if (stretch_on && log_q.size() != logged) begin
                logged = log_q.size();
                stretch_len <= STRETCH_MIN + ($unsigned($random(seed)) % STRETCH_SPAN);
            end
        end
        repeat (2) @(negedge CLK);
        check_log(name);
        compare_flag(done_o, 1'b1, {name, " done_o"});
        compare_flag(scl_drive_low_o, 1'b0, {name, " scl_drive_low_o after done"});
        compare_flag(sda_drive_low_o, 1'b0, {name, " sda_drive_low_o after done"});
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        reset_dut(1'b1);
        @(negedge CLK);
        check_idle("one cycle after reset");
        // The slave decodes on one falling edge and the log fills on the next rising edge
        // The first real START needs half an SCL period, so the bus is still quiet here
        repeat (2) @(negedge CLK);
        compare_flag(log_q.size() == 0, 1'b1, "bus stays quiet before the first command");
    endtask

    task automatic clean_init();
        int entries;
        run_init("clean init", -1, 0, 1'b0);
        entries = log_q.size();
        // After the sequence the master stays parked with done held
        repeat (8 * HALF) @(negedge CLK);
        compare_flag(done_o, 1'b1, "done_o holds after the sequence");
        compare_flag(log_q.size() == entries, 1'b1, "no bus traffic after done");
    endtask

    task automatic nack_in_group_b();
        // Entry 3 is the control register index of the CPLD write
        run_init("NACK in group B", 3, 1, 1'b0);
    endtask

    task automatic nack_on_switch_addr();
        run_init("NACK on switch address", 0, 1, 1'b0);
    endtask

    task automatic clock_stretching();
        run_init("clock stretching", -1, 0, 1'b1);
        compare_flag(min_high >= HALF, 1'b1,
                     $sformatf("shortest SCL high phase is %0d cycles", min_high));
        compare_flag(max_low > HALF, 1'b1,
                     $sformatf("longest SCL low phase is %0d cycles", max_low));
    endtask

    initial begin
        CLK           = 1'b0;
        delay_rst_reg = 1'b1;
        scl_i         = 1'b1;
        sda_i         = 1'b1;
        nack_data     = 8'h00;
        nack_attempt  = 0;
        stretch_len   = 0;
        seed          = 32'h2a76;
        error_count   = 0;
        cycle_cnt     = 0;
        idle_after_reset();
        clean_init();
        nack_in_group_b();
        nack_on_switch_addr();
        clock_stretching();
        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
